//--- tb.f
+incdir+include
design/vchess_pkg.sv
design/board_store.sv
design/rank_score.sv
design/eval_sum.sv
design/vchess_top.sv
test/vchess_assert.sv
test/vchess_tb.sv

//--- test/vchess_tb.sv
`timescale 1ns/10ps

`include "vchess_config.svh"

module vchess_tb;

   typedef struct packed {
      logic [2:0]                  count;      // Number of writes used
      vchess_pkg::sq_write_t [3:0] writes;
      logic                        white;
      logic                        commit;
   } row_t;

   logic                  clk = 1'b0;
   logic                  arst_n;
   logic                  sq_wr;
   vchess_pkg::sq_write_t sq_wr_data;
   logic                  commit;
   logic                  white_to_move;
   vchess_pkg::eval_t     eval;
   logic                  eval_valid;

   row_t                  rows[$];
   string                 row_names[$];
   vchess_pkg::eval_t     exp_q[$];        // Expected scores in commit order
   string                 exp_names[$];
   vchess_pkg::piece_t    ref_board[`VCHESS_SQUARES];
   int unsigned           rng_state = 76452;
   bit                    table_ready = 1'b0;

   int kind_value [0:7] = '{0, `VCHESS_PAWN_VALUE, `VCHESS_KNIGHT_VALUE, `VCHESS_BISHOP_VALUE,
                            `VCHESS_ROOK_VALUE, `VCHESS_QUEEN_VALUE, 0, 0};

   vchess_top vchess_top_inst
   (
      .clk           (clk),
      .arst_n        (arst_n),
      .sq_wr         (sq_wr),
      .sq_wr_data    (sq_wr_data),
      .commit        (commit),
      .white_to_move (white_to_move),
      .eval          (eval),
      .eval_valid    (eval_valid)
   );

   always #2 clk = ~clk;

   function automatic int unsigned lcg_next();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state >> 16;
   endfunction

   function automatic vchess_pkg::piece_t make_piece(bit black, int kind);
      vchess_pkg::piece_t p;
      p.black = black;
      p.kind  = vchess_pkg::piece_kind_e'(kind[2:0]);
      return p;
   endfunction

   function automatic vchess_pkg::sq_write_t make_write(int addr, bit black, int kind);
      vchess_pkg::sq_write_t w;
      w.addr  = addr[5:0];
      w.piece = make_piece(black, kind);
      return w;
   endfunction

   task automatic add_row(string name, int n, vchess_pkg::sq_write_t w0,
                          vchess_pkg::sq_write_t w1, vchess_pkg::sq_write_t w2,
                          vchess_pkg::sq_write_t w3, bit white, bit do_commit);
      row_t r;
      r.count  = n[2:0];
      r.writes = {w3, w2, w1, w0};
      r.white  = white;
      r.commit = do_commit;
      rows.push_back(r);
      row_names.push_back(name);
   endtask

   function automatic void reset_model();
      int back_rank [0:7] = '{4, 2, 3, 5, 6, 3, 2, 4};   // a-file to h-file
      for (int sq = 0; sq < `VCHESS_SQUARES; sq++)
         ref_board[sq] = '0;
      for (int f = 0; f < 8; f++)
      begin
         ref_board[f]      = make_piece(1'b0, back_rank[f]);
         ref_board[8 + f]  = make_piece(1'b0, 1);
         ref_board[48 + f] = make_piece(1'b1, 1);
         ref_board[56 + f] = make_piece(1'b1, back_rank[f]);
      end
   endfunction

   // Material of white minus black from the mover's view
   function automatic vchess_pkg::eval_t material_score(bit white);
      int total;
      total = 0;
      for (int sq = 0; sq < `VCHESS_SQUARES; sq++)
      begin
         if (ref_board[sq].black)
            total -= kind_value[ref_board[sq].kind];
         else
            total += kind_value[ref_board[sq].kind];
      end
      if (!white)
         total = -total;
      return vchess_pkg::eval_t'(total);
   endfunction

   task automatic build_table();
      vchess_pkg::sq_write_t none;
      vchess_pkg::sq_write_t w[4];
      none = '0;
      add_row("start_white", 0, none, none, none, none, 1'b1, 1'b1);
      add_row("start_black", 0, none, none, none, none, 1'b0, 1'b1);
      add_row("clear_d8_white", 1, make_write(59, 0, 0), none, none, none, 1'b1, 1'b1);
      add_row("clear_d8_black", 0, none, none, none, none, 1'b0, 1'b1);
      add_row("same_cycle_a1", 1, make_write(0, 0, 0), none, none, none, 1'b1, 1'b1);
      add_row("consec_e2", 1, make_write(12, 0, 0), none, none, none, 1'b1, 1'b1);
      add_row("consec_a8", 1, make_write(56, 0, 0), none, none, none, 1'b0, 1'b1);
      add_row("consec_d1", 1, make_write(3, 0, 0), none, none, none, 1'b1, 1'b1);
      add_row("consec_d4_queen", 2, make_write(27, 1, 5), make_write(28, 0, 2), none,
              none, 1'b0, 1'b1);
      for (int i = 0; i < 20; i++)
      begin
         for (int k = 0; k < 4; k++)
            w[k] = make_write(lcg_next() % 64, lcg_next() % 2, lcg_next() % 7);
         add_row($sformatf("random_%0d", i), lcg_next() % 5, w[0], w[1], w[2], w[3],
                 lcg_next() % 2, (lcg_next() % 4) != 0);
      end
   endtask

   // One cycle per write with the commit on the last one
   task automatic apply_row(int idx);
      row_t r;
      int   cycles;
      bit   last;
      r      = rows[idx];
      cycles = (r.count == 0) ? 1 : r.count;
      for (int c = 0; c < cycles; c++)
      begin
         last = (c == cycles - 1);
         @(posedge clk);
         sq_wr         <= (c < r.count);
         sq_wr_data    <= r.writes[c];
         white_to_move <= r.white;
         commit        <= r.commit && last;
         if (c < r.count)
            ref_board[r.writes[c].addr] = r.writes[c].piece;
         if (r.commit && last)
         begin
            exp_q.push_back(material_score(r.white));
            exp_names.push_back(row_names[idx]);
         end
      end
   endtask

   task automatic check_value(string name, vchess_pkg::eval_t expected,
                              vchess_pkg::eval_t actual);
      if (expected !== actual)
      begin
         $display("ERR %s expected %0d actual %0d", name, expected, actual);
         $display("Regression failed");
         $fatal(1, "score mismatch");
      end
   endtask

   always @(posedge clk)
   begin
      if (vchess_top_inst.vchess_assert_inst.fail_count != 0)
      begin
         $display("Assertion failure reported by the bound checker");
         $display("Regression failed");
         $fatal(1, "assertion failure");
      end
      else if (arst_n === 1'b1 && eval_valid === 1'b1)
      begin
         if (exp_q.size() == 0)
         begin
            $display("Unexpected result: eval_valid arrived with no commit pending");
            $display("Regression failed");
            $fatal(1, "unexpected result");
         end
         else
            check_value(exp_names.pop_front(), exp_q.pop_front(), eval);
      end
   end

   initial
   begin
      wait (table_ready);
      repeat (rows.size() * 10 + 100) @(posedge clk);
      $display("Timeout: not all expected results arrived before the watchdog expired");
      $display("Regression failed");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      arst_n        = 1'b1;
      sq_wr         = 1'b0;
      sq_wr_data    = '0;
      commit        = 1'b0;
      white_to_move = 1'b1;
      build_table();
      reset_model();
      table_ready = 1'b1;
      #1;
      arst_n = 1'b0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      for (int i = 0; i < rows.size(); i++)
         apply_row(i);
      @(posedge clk);
      sq_wr  <= 1'b0;
      commit <= 1'b0;
      wait (exp_q.size() == 0);
      repeat (5) @(posedge clk);                 // Catch stray results
      if (vchess_top_inst.vchess_assert_inst.fail_count == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

//--- test/vchess_assert.sv
`timescale 1ns/10ps

module vchess_assert
(
   input logic              clk,
   input logic              arst_n,
   input logic              commit,
   input vchess_pkg::eval_t eval,
   input logic              eval_valid
);

   int fail_count = 0;                // Read by the testbench

   // No result may leave the pipeline during reset
   a_quiet_in_reset : assert property (@(posedge clk) !arst_n |-> !eval_valid)
   else
   begin
      fail_count++;
      $error("eval_valid high during reset");
   end

   // Commit sampled, snapshot, rank totals, then the result
   a_latency : assert property (@(posedge clk) disable iff (!arst_n)
      commit |=> ##2 eval_valid)
   else
   begin
      fail_count++;
      $error("eval_valid missing after commit");
   end

   a_no_spurious : assert property (@(posedge clk) disable iff (!arst_n)
      eval_valid |-> $past(commit, 3))
   else
   begin
      fail_count++;
      $error("eval_valid without a matching commit");
   end

   a_known_eval : assert property (@(posedge clk) disable iff (!arst_n)
      eval_valid |-> !$isunknown(eval))
   else
   begin
      fail_count++;
      $error("eval unknown while eval_valid high");
   end

endmodule

bind vchess_top vchess_assert vchess_assert_inst
(
   .clk        (clk),
   .arst_n     (arst_n),
   .commit     (commit),
   .eval       (eval),
   .eval_valid (eval_valid)
);

//--- design/vchess_top.sv
`timescale 1ns/10ps

`include "vchess_config.svh"

module vchess_top
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  sq_wr,
   input  vchess_pkg::sq_write_t sq_wr_data,
   input  logic                  commit,
   input  logic                  white_to_move,
   output vchess_pkg::eval_t     eval,
   output logic                  eval_valid
);

   localparam int RANKS = `VCHESS_SQUARES / `VCHESS_FILES;

   vchess_pkg::board_t             snap_board;
   logic                           snap_white;
   logic                           snap_valid;
   vchess_pkg::eval_t [RANKS-1:0]  rank_vals;
   logic [RANKS-1:0]               rank_valid;   // All ranks share timing

   board_store board_store_inst
   (
      .clk           (clk),
      .arst_n        (arst_n),
      .sq_wr         (sq_wr),
      .sq_wr_data    (sq_wr_data),
      .commit        (commit),
      .white_to_move (white_to_move),
      .snap_board    (snap_board),
      .snap_white    (snap_white),
      .snap_valid    (snap_valid)
   );

   // One scorer per rank
   for (genvar r = 0; r < RANKS; r++)
   begin : g_rank
      rank_score rank_score_inst
      (
         .clk        (clk),
         .arst_n     (arst_n),
         .rank_in    (snap_board[r]),
         .in_valid   (snap_valid),
         .rank_val   (rank_vals[r]),
         .rank_valid (rank_valid[r])
      );
   end

   eval_sum eval_sum_inst
   (
      .clk           (clk),
      .arst_n        (arst_n),
      .rank_vals     (rank_vals),
      .in_valid      (rank_valid[0]),
      .white_to_move (snap_white),
      .eval          (eval),
      .eval_valid    (eval_valid)
   );

endmodule

//--- design/eval_sum.sv
`timescale 1ns/10ps

`include "vchess_config.svh"

module eval_sum
(
   input  logic                                       clk,
   input  logic                                       arst_n,
   input  vchess_pkg::eval_t [`VCHESS_SQUARES/`VCHESS_FILES-1:0] rank_vals,
   input  logic                                       in_valid,
   input  logic                                       white_to_move,
   output vchess_pkg::eval_t                          eval,
   output logic                                       eval_valid
);

   localparam int RANKS = `VCHESS_SQUARES / `VCHESS_FILES;

   vchess_pkg::eval_t total;          // White minus black
   logic              white_d;        // Side to move, aligned with rank totals

   always_comb
   begin
      total = '0;
      for (int r = 0; r < RANKS; r++)
         total = total + rank_vals[r];
   end

   // Snapshot side arrives one stage ahead of the rank scores
   always_ff @(posedge clk)
   begin
      white_d <= white_to_move;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         eval       <= '0;
         eval_valid <= 1'b0;
      end
      else
      begin
         eval_valid <= in_valid;
         if (in_valid)
            eval <= white_d ? total : -total; // Score from mover's view
      end
   end

endmodule

//--- design/rank_score.sv
`timescale 1ns/10ps

`include "vchess_config.svh"

module rank_score
(
   input  logic               clk,
   input  logic               arst_n,
   input  vchess_pkg::rank_t  rank_in,
   input  logic               in_valid,
   output vchess_pkg::eval_t  rank_val,
   output logic               rank_valid
);

   vchess_pkg::eval_t rank_sum;

   // Signed material value of one square
   function automatic vchess_pkg::eval_t piece_value(vchess_pkg::piece_t p);
      vchess_pkg::eval_t v;
      case (p.kind)
         vchess_pkg::KIND_PAWN:   v = `VCHESS_PAWN_VALUE;
         vchess_pkg::KIND_KNIGHT: v = `VCHESS_KNIGHT_VALUE;
         vchess_pkg::KIND_BISHOP: v = `VCHESS_BISHOP_VALUE;
         vchess_pkg::KIND_ROOK:   v = `VCHESS_ROOK_VALUE;
         vchess_pkg::KIND_QUEEN:  v = `VCHESS_QUEEN_VALUE;
         default:                 v = '0;        // Empty or king
      endcase
      return p.black ? -v : v;
   endfunction

   always_comb
   begin
      rank_sum = '0;
      for (int f = 0; f < `VCHESS_FILES; f++)
         rank_sum = rank_sum + piece_value(rank_in[f]);
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rank_val   <= '0;
         rank_valid <= 1'b0;
      end
      else
      begin
         rank_valid <= in_valid;
         if (in_valid)
            rank_val <= rank_sum;     // Hold last total between snapshots
      end
   end

endmodule

//--- design/board_store.sv
`timescale 1ns/10ps

`include "vchess_config.svh"

module board_store
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  sq_wr,
   input  vchess_pkg::sq_write_t sq_wr_data,
   input  logic                  commit,
   input  logic                  white_to_move,
   output vchess_pkg::board_t    snap_board,
   output logic                  snap_white,
   output logic                  snap_valid
);

   vchess_pkg::board_t board;         // Live position
   vchess_pkg::board_t board_next;    // Live position with this cycle's write

   // Standard opening setup
   function automatic vchess_pkg::board_t start_position();
      vchess_pkg::board_t      b;
      vchess_pkg::piece_kind_e kind;
      b = '0;
      for (int f = 0; f < `VCHESS_FILES; f++)
      begin
         case (f)
            0, 7:    kind = vchess_pkg::KIND_ROOK;
            1, 6:    kind = vchess_pkg::KIND_KNIGHT;
            2, 5:    kind = vchess_pkg::KIND_BISHOP;
            3:       kind = vchess_pkg::KIND_QUEEN;
            default: kind = vchess_pkg::KIND_KING;
         endcase
         b[0][f] = '{black: 1'b0, kind: kind};
         b[1][f] = '{black: 1'b0, kind: vchess_pkg::KIND_PAWN};
         b[6][f] = '{black: 1'b1, kind: vchess_pkg::KIND_PAWN};
         b[7][f] = '{black: 1'b1, kind: kind};
      end
      return b;
   endfunction

   always_comb
   begin
      board_next = board;
      if (sq_wr)
         board_next[sq_wr_data.addr[5:3]][sq_wr_data.addr[2:0]] = sq_wr_data.piece; // Rank, file
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         board <= start_position();
      else
         board <= board_next;
   end

   // Snapshot includes a write landing in the commit cycle
   always_ff @(posedge clk)
   begin
      if (commit)
      begin
         snap_board <= board_next;
         snap_white <= white_to_move;
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         snap_valid <= 1'b0;
      else
         snap_valid <= commit;        // One-cycle pulse
   end

endmodule

//--- design/vchess_pkg.sv
`include "vchess_config.svh"

package vchess_pkg;

   // Piece kind without colour
   typedef enum logic [`VCHESS_PIECE_BITS-2:0] {
      KIND_EMPTY  = 3'd0,
      KIND_PAWN   = 3'd1,
      KIND_KNIGHT = 3'd2,
      KIND_BISHOP = 3'd3,
      KIND_ROOK   = 3'd4,
      KIND_QUEEN  = 3'd5,
      KIND_KING   = 3'd6
   } piece_kind_e;

   // One square code
   typedef struct packed {
      logic        black;             // Set for black pieces
      piece_kind_e kind;
   } piece_t;

   // File 0 is the a-file
   typedef piece_t [`VCHESS_FILES-1:0] rank_t;

   // Rank 0 is white's back rank
   typedef rank_t [`VCHESS_SQUARES/`VCHESS_FILES-1:0] board_t;

   // Square update with addr as rank * 8 + file
   typedef struct packed {
      logic [5:0] addr;
      piece_t     piece;
   } sq_write_t;

   // Positive favours the side to move
   typedef logic signed [`VCHESS_EVAL_WIDTH-1:0] eval_t;

endpackage

//--- include/vchess_config.svh
`ifndef VCHESS_CONFIG_SVH
`define VCHESS_CONFIG_SVH

// Board geometry
`define VCHESS_PIECE_BITS 4
`define VCHESS_SQUARES 64
`define VCHESS_FILES 8

// Signed score width with headroom over full material
`define VCHESS_EVAL_WIDTH 22

// Material values in centipawns with the king at 0
`define VCHESS_PAWN_VALUE 100
`define VCHESS_KNIGHT_VALUE 320
`define VCHESS_BISHOP_VALUE 330
`define VCHESS_ROOK_VALUE 500
`define VCHESS_QUEEN_VALUE 900

`endif
